// ==== src.f ====
+incdir+include
logic/corr_pkg.sv
logic/lane_sequencer.sv
logic/code_correlator.sv
logic/code_decision.sv
logic/dual_code_detector.sv
tests/dual_code_detector_props.sv
tests/dual_code_detector_tb.sv

// ==== Bender.yml ====
package:
  name: dual_code_detector

sources:
  - include_dirs:
      - include
    files:
      - logic/corr_pkg.sv
      - logic/lane_sequencer.sv
      - logic/code_correlator.sv
      - logic/code_decision.sv
      - logic/dual_code_detector.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/dual_code_detector_props.sv
      - tests/dual_code_detector_tb.sv

// ==== tests/dual_code_detector_tb.sv ====
/*
  Testbench for the dual-code burst detector:
  clock and reset, LFSR stimulus with directed code bursts,
  reference model with an expected-word queue,
  result checks, cycle limit and closing summary
*/

`timescale 1ns/1ps

`include "corr_macros.svh"

module dual_code_detector_tb;

  localparam int NUM_CH = `CORR_NUM_CH;
  localparam int LEN = `CORR_LEN;
  localparam logic [LEN-1:0] CODE_A = `CORR_CODE_A;
  localparam logic [LEN-1:0] CODE_B = `CORR_CODE_B;

  localparam int KIND_RANDOM = 0;
  localparam int KIND_CODE_A = 1;
  localparam int KIND_CODE_B = 2;
  localparam int KIND_SMALL = 3;

  localparam int TAG_NONE = 0;
  localparam int TAG_PEAK_A = 1;
  localparam int TAG_PEAK_B = 2;
  localparam int TAG_QUIET = 3;

  // 90 words at about 8 cycles each, plus reset, hold and drain
  localparam int EXPECTED_CYCLES = 8 + 90 * 8 + 20 + 40;
  localparam int CYCLE_LIMIT = 2 * EXPECTED_CYCLES;

  localparam corr_pkg::ch_result_t PEAK_A = '{detect: 1'b1, code_b: 1'b0, mag: 12'd800};
  localparam corr_pkg::ch_result_t PEAK_B = '{detect: 1'b1, code_b: 1'b1, mag: 12'd800};

  logic                   clk;
  logic                   arst_n;
  logic                   s_valid;
  logic                   s_ready;
  corr_pkg::sample_word_t s_data;
  logic                   m_valid;
  logic                   m_ready;
  corr_pkg::result_word_t m_data;

  logic [15:0]            lfsr = 16'd45371;
  int                     ready_mode = 0;
  int                     cur_tag = TAG_NONE;
  int                     hist [NUM_CH][LEN];
  corr_pkg::result_word_t exp_q [$];
  int                     tag_q [$];
  int                     mismatch_errors = 0;
  int                     other_errors = 0;
  int                     cycle_count = 0;

  dual_code_detector dut_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random source and stimulus
  ////////////////////////////////////////////////////////////

  // taps 16, 14, 13, 11; one step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic corr_pkg::sample_word_t build_word(input int kind, input int idx);
    corr_pkg::sample_word_t w;
    logic [31:0]            r;
    for (int c = 0; c < NUM_CH; c++) begin
      if (kind == KIND_SMALL) begin
        // 7-bit range keeps eight samples below the threshold
        r = draw_bits(7);
        w[c] = {r[6], r[6:0]};
      end else begin
        r = draw_bits(8);
        w[c] = r[7:0];
      end
    end
    if (kind == KIND_CODE_A) begin
      w[1] = CODE_A[idx] ? 8'sd100 : -8'sd100;
    end
    if (kind == KIND_CODE_B) begin
      w[2] = CODE_B[idx] ? 8'sd100 : -8'sd100;
    end
    return w;
  endfunction

  // one falling edge, with the output ready for the next cycle
  task automatic step_cycle();
    @(negedge clk);
    case (ready_mode)
      0: m_ready = (draw_bits(2) != 0);
      1: m_ready = 1'b0;
      default: m_ready = 1'b1;
    endcase
  endtask

  task automatic send_word(input corr_pkg::sample_word_t w);
    logic taken;
    s_valid = 1'b1;
    s_data = w;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = s_ready;
      step_cycle();
    end
    s_valid = 1'b0;
  endtask

  task automatic run_words(input int kind, input int count, input bit gaps);
    int gap;
    for (int i = 0; i < count; i++) begin
      cur_tag = TAG_NONE;
      if (kind == KIND_CODE_A && i == LEN - 1) begin
        cur_tag = TAG_PEAK_A;
      end else if (kind == KIND_CODE_B && i == LEN - 1) begin
        cur_tag = TAG_PEAK_B;
      end else if (kind == KIND_SMALL && i >= LEN - 1) begin
        cur_tag = TAG_QUIET;
      end
      send_word(build_word(kind % 4, i % LEN));
      if (gaps) begin
        gap = draw_bits(2);
        repeat (gap) step_cycle();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////

  // hist[c][k] holds x[t-7+k], bit k of each code meets it
  function automatic corr_pkg::ch_result_t expect_channel(input int c);
    corr_pkg::ch_result_t r;
    int                   sa;
    int                   sb;
    int                   ma;
    int                   mb;
    sa = 0;
    sb = 0;
    for (int k = 0; k < LEN; k++) begin
      sa += CODE_A[k] ? hist[c][k] : -hist[c][k];
      sb += CODE_B[k] ? hist[c][k] : -hist[c][k];
    end
    ma = (sa < 0) ? -sa : sa;
    mb = (sb < 0) ? -sb : sb;
    r.code_b = mb > ma;
    r.mag = corr_pkg::mag_t'(r.code_b ? mb : ma);
    r.detect = (r.code_b ? mb : ma) >= `CORR_THRESHOLD;
    return r;
  endfunction

  task automatic push_expected();
    corr_pkg::result_word_t w;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int k = 0; k < LEN - 1; k++) begin
        hist[c][k] = hist[c][k+1];
      end
      hist[c][LEN-1] = int'(s_data[c]);
      w[c] = expect_channel(c);
    end
    exp_q.push_back(w);
    tag_q.push_back(cur_tag);
  endtask

  task automatic check_channel(input int c, input corr_pkg::ch_result_t exp_r);
    assert (m_data[c] == exp_r) else begin
      $display("mismatch at %0t: m_data[%0d] expected %h got %h", $time, c, exp_r, m_data[c]);
      mismatch_errors++;
    end
  endtask

  task automatic check_output();
    corr_pkg::result_word_t exp_w;
    int                     tag;
    assert (exp_q.size() != 0) else begin
      $display("output word at %0t with no accepted input left to match it", $time);
      other_errors++;
    end
    if (exp_q.size() != 0) begin
      exp_w = exp_q.pop_front();
      tag = tag_q.pop_front();
      assert (m_data == exp_w) else begin
        $display("mismatch at %0t: m_data expected %h got %h", $time, exp_w, m_data);
        mismatch_errors++;
      end
      if (tag == TAG_PEAK_A) begin
        check_channel(1, PEAK_A);
      end else if (tag == TAG_PEAK_B) begin
        check_channel(2, PEAK_B);
      end else if (tag == TAG_QUIET) begin
        for (int c = 0; c < NUM_CH; c++) begin
          assert (!m_data[c].detect) else begin
            $display("mismatch at %0t: m_data[%0d].detect expected 0 got 1", $time, c);
            mismatch_errors++;
          end
        end
      end
    end
  endtask

  // output first, then the word accepted on the same edge
  always @(posedge clk) begin
    if (arst_n) begin
      if (m_valid && m_ready) begin
        check_output();
      end
      if (s_valid && s_ready) begin
        push_expected();
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d results outstanding",
               cycle_count, exp_q.size());
      $display("errors: %0d mismatch, %0d protocol, %0d other",
               mismatch_errors, dut_i.props_i.fail_count, other_errors);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int total;
    arst_n = 1'b0;
    s_valid = 1'b0;
    s_data = '0;
    m_ready = 1'b0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    repeat (3) step_cycle();

    run_words(KIND_RANDOM, 40, 1'b1);
    run_words(KIND_CODE_A, 8, 1'b1);
    run_words(KIND_CODE_B, 8, 1'b1);
    run_words(KIND_SMALL, 16, 1'b1);

    // empty pipeline first, so both held words get accepted
    while (exp_q.size() != 0) begin
      step_cycle();
    end

    // output held off with two words inside the pipeline
    ready_mode = 1;
    m_ready = 1'b0;
    run_words(KIND_RANDOM, 2, 1'b0);
    repeat (20) step_cycle();

    // free-running output, words back to back
    ready_mode = 2;
    m_ready = 1'b1;
    run_words(KIND_RANDOM, 16, 1'b0);

    ready_mode = 0;
    while (exp_q.size() != 0) begin
      step_cycle();
    end
    repeat (10) step_cycle();

    total = mismatch_errors + other_errors + dut_i.props_i.fail_count;
    $display("errors: %0d mismatch, %0d protocol, %0d other",
             mismatch_errors, dut_i.props_i.fail_count, other_errors);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== tests/dual_code_detector_props.sv ====
/*
  Protocol checks for the dual-code burst detector:
  reset state, output hold under back-pressure,
  fixed latency with free-running output, known control
  and the bind onto the top level
*/

`timescale 1ns/1ps

module dual_code_detector_props (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   s_valid,
  input logic                   s_ready,
  input logic                   m_valid,
  input logic                   m_ready,
  input corr_pkg::result_word_t m_data
);

  // failed assertions, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk) !arst_n |-> !m_valid)
    else begin
      $error("m_valid high while reset is asserted");
      fail_count++;
    end

  // idle and ready before the first word
  assert property (@(posedge clk) $rose(arst_n) |-> !m_valid && s_ready)
    else begin
      $error("detector not idle and ready after reset release");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////
  // output stream
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else begin
      $error("output word dropped or changed while stalled");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown({s_ready, m_valid}) && (m_valid -> !$isunknown(m_data)))
    else begin
      $error("unknown value on the stream handshake or output data");
      fail_count++;
    end

  // six edges from input transfer to result when nothing stalls
  assert property (@(posedge clk) disable iff (!arst_n)
    (s_valid && s_ready && m_ready) ##1 m_ready [*6] |=> $rose(m_valid))
    else begin
      $error("result did not appear six cycles after the input transfer");
      fail_count++;
    end

endmodule

bind dual_code_detector dual_code_detector_props props_i (
  .clk     (clk),
  .arst_n  (arst_n),
  .s_valid (s_valid),
  .s_ready (s_ready),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data)
);

// ==== logic/dual_code_detector.sv ====
/*
  Dual-code burst detector top level:
  lane sequencer, code A and code B correlators
  and the decision block on one shared pipeline enable
*/

`timescale 1ns/1ps

`include "corr_macros.svh"

module dual_code_detector (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  corr_pkg::sample_word_t s_data,
  output logic                   m_valid,
  input  logic                   m_ready,
  output corr_pkg::result_word_t m_data
);

  corr_pkg::lane_t     lane;
  logic                lane_valid;
  corr_pkg::bank_out_t a_out;
  corr_pkg::bank_out_t b_out;
  logic                a_valid;
  logic                b_valid;
  logic                advance;

  lane_sequencer seq_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .advance    (advance),
    .lane       (lane),
    .lane_valid (lane_valid)
  );

  // two correlators on the same lanes
  code_correlator #(.code(`CORR_CODE_A)) corr_a_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .advance    (advance),
    .lane       (lane),
    .lane_valid (lane_valid),
    .bank_out   (a_out),
    .bank_valid (a_valid)
  );

  code_correlator #(.code(`CORR_CODE_B)) corr_b_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .advance    (advance),
    .lane       (lane),
    .lane_valid (lane_valid),
    .bank_out   (b_out),
    .bank_valid (b_valid)
  );

  code_decision dec_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .a_out   (a_out),
    .b_out   (b_out),
    .a_valid (a_valid),
    .b_valid (b_valid),
    .advance (advance),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

endmodule

// ==== logic/code_decision.sv ====
/*
  Decision and output stage of the burst detector:
  per-channel magnitude compare between code A and code B,
  threshold detect, collection of channel results into a word,
  registered valid/ready output and the shared pipeline enable
*/

`timescale 1ns/1ps

`include "corr_macros.svh"

module code_decision (
  input  logic                   clk,
  input  logic                   arst_n,
  input  corr_pkg::bank_out_t    a_out,
  input  corr_pkg::bank_out_t    b_out,
  input  logic                   a_valid,
  input  logic                   b_valid,
  output logic                   advance,
  output logic                   m_valid,
  input  logic                   m_ready,
  output corr_pkg::result_word_t m_data
);

  corr_pkg::mag_t         mag_a;
  corr_pkg::mag_t         mag_b;
  corr_pkg::ch_result_t   res;
  corr_pkg::result_word_t stage_q;
  corr_pkg::result_word_t stage_next;
  logic                   in_valid;
  logic                   in_last;
  logic                   load_out;

  // sums stay well inside the signed range, so negation cannot wrap
  function automatic corr_pkg::mag_t abs_val(input corr_pkg::acc_t v);
    if (v < 0) begin
      return corr_pkg::mag_t'(-v);
    end
    return corr_pkg::mag_t'(v);
  endfunction

  // both correlators run in lockstep on the same lanes
  assign in_valid = a_valid && b_valid;
  assign in_last  = a_out.last && b_out.last;

  ////////////////////////////////////////////////////////////
  // per-channel decision
  ////////////////////////////////////////////////////////////

  assign mag_a = abs_val(a_out.value);
  assign mag_b = abs_val(b_out.value);

  always_comb begin
    // ties go to code A
    res.code_b = mag_b > mag_a;
    res.mag    = res.code_b ? mag_b : mag_a;
    res.detect = res.mag >= corr_pkg::mag_t'(`CORR_THRESHOLD);
  end

  // staged word with the current channel filled in
  always_comb begin
    stage_next = stage_q;
    stage_next[a_out.ch] = res;
  end

  ////////////////////////////////////////////////////////////
  // staging word
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance && in_valid) begin
      stage_q <= stage_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // output register and stall
  ////////////////////////////////////////////////////////////

  // hold everything while a full output word waits
  assign advance  = !m_valid || m_ready;
  assign load_out = advance && in_valid && in_last;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (advance) begin
      m_valid <= in_valid && in_last;
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      m_data <= stage_next;
    end
  end

endmodule

// ==== logic/code_correlator.sv ====
/*
  Time-multiplexed correlator against one fixed +/-1 code:
  transposed adder chain with a partial-sum register per tap
  and per channel, one channel served each cycle,
  registered correlation value with channel and last tag
*/

`timescale 1ns/1ps

`include "corr_macros.svh"

module code_correlator #(
  parameter logic [`CORR_LEN-1:0] code = `CORR_CODE_A
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                advance,
  input  corr_pkg::lane_t     lane,
  input  logic                lane_valid,
  output corr_pkg::bank_out_t bank_out,
  output logic                bank_valid
);

  // stored sums of taps 0..LEN-2, the last tap goes straight to the output
  corr_pkg::acc_t part_q [`CORR_NUM_CH][`CORR_LEN-1];

  corr_pkg::acc_t tap [`CORR_LEN];
  corr_pkg::acc_t x;
  logic           step;

  assign step = advance && lane_valid;

  // sign-extend the incoming sample to the adder width
  assign x = corr_pkg::acc_t'(lane.sample);

  ////////////////////////////////////////////////////////////
  // adder chain for the channel in this slot
  ////////////////////////////////////////////////////////////

  always_comb begin
    // tap 0 starts the chain from zero
    tap[0] = code[0] ? x : -x;
    for (int j = 1; j < `CORR_LEN; j++) begin
      if (code[j]) begin
        tap[j] = part_q[lane.ch][j-1] + x;
      end else begin
        tap[j] = part_q[lane.ch][j-1] - x;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // partial sums per channel
  ////////////////////////////////////////////////////////////

  // history before reset counts as zero, so the sums clear
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int c = 0; c < `CORR_NUM_CH; c++) begin
        for (int j = 0; j < `CORR_LEN - 1; j++) begin
          part_q[c][j] <= '0;
        end
      end
    end else if (step) begin
      for (int j = 0; j < `CORR_LEN - 1; j++) begin
        part_q[lane.ch][j] <= tap[j];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bank_valid <= 1'b0;
    end else if (advance) begin
      bank_valid <= lane_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      bank_out.ch    <= lane.ch;
      bank_out.value <= tap[`CORR_LEN-1];
      bank_out.last  <= lane.last;
    end
  end

endmodule

// ==== logic/lane_sequencer.sv ====
/*
  Input stage of the burst detector:
  accepts one sample word per valid/ready transfer and
  steps its channel samples out one per cycle as lanes,
  marking the last channel
*/

`timescale 1ns/1ps

`include "corr_macros.svh"

module lane_sequencer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  corr_pkg::sample_word_t s_data,
  input  logic                   advance,
  output corr_pkg::lane_t        lane,
  output logic                   lane_valid
);

  corr_pkg::sample_word_t word_q;
  corr_pkg::ch_idx_t      cnt_q;
  logic                   busy_q;
  logic                   sel_last;
  logic                   s_xfer;

  // buffer is on its final channel when cnt reaches the top
  assign sel_last = busy_q && (cnt_q == `CORR_CH_W'(`CORR_NUM_CH - 1));

  // next word may land as the last channel leaves the buffer
  assign s_ready = advance && (!busy_q || sel_last);
  assign s_xfer  = s_valid && s_ready;

  ////////////////////////////////////////////////////////////
  // word buffer and channel counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (advance) begin
      if (s_xfer) begin
        busy_q <= 1'b1;
      end else if (sel_last) begin
        busy_q <= 1'b0;
      end
      if (sel_last) begin
        cnt_q <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_xfer) begin
      word_q <= s_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // lane register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_valid <= 1'b0;
    end else if (advance) begin
      lane_valid <= busy_q;
    end
  end

  // payload only, qualified by lane_valid
  always_ff @(posedge clk) begin
    if (advance && busy_q) begin
      lane.ch     <= cnt_q;
      lane.sample <= word_q[cnt_q];
      lane.last   <= sel_last;
    end
  end

endmodule

// ==== logic/corr_pkg.sv ====
/*
  Shared types of the dual-code burst detector:
  sample and sample word, lane slot, correlator output,
  per-channel result and the output result word
*/

`include "corr_macros.svh"

package corr_pkg;

  ////////////////////////////////////////////////////////////
  // samples
  ////////////////////////////////////////////////////////////

  typedef logic signed [`CORR_SAMPLE_W-1:0] sample_t;

  // channel 0 in the low bits
  typedef sample_t [`CORR_NUM_CH-1:0] sample_word_t;

  typedef logic [`CORR_CH_W-1:0] ch_idx_t;

  // one channel's slot of work
  typedef struct packed {
    ch_idx_t ch;
    sample_t sample;
    logic    last;
  } lane_t;

  ////////////////////////////////////////////////////////////
  // partial sums and results
  ////////////////////////////////////////////////////////////

  typedef logic signed [`CORR_ACC_W-1:0] acc_t;
  typedef logic [`CORR_ACC_W-1:0] mag_t;

  typedef struct packed {
    ch_idx_t ch;
    acc_t    value;
    logic    last;
  } bank_out_t;

  typedef struct packed {
    logic detect;
    logic code_b;
    mag_t mag;
  } ch_result_t;

  // channel 0 in the low bits
  typedef ch_result_t [`CORR_NUM_CH-1:0] result_word_t;

endpackage

// ==== include/corr_macros.svh ====
/*
  Burst detector configuration macros:
  channel count, sample and partial-sum widths,
  code length, the two fixed +/-1 codes and the detection threshold
*/

`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// channels interleaved in one input word
`define CORR_NUM_CH 4
`define CORR_CH_W 2

// signed sample width
`define CORR_SAMPLE_W 8

// taps per code
`define CORR_LEN 8

// eight full-scale samples need 11 bits plus sign
`define CORR_ACC_W 12

// set bit is +1, clear bit is -1; bit 0 meets the oldest sample
`define CORR_CODE_A 8'b1011_1000
`define CORR_CODE_B 8'b0111_0010

// magnitude at or above this flags a detection
`define CORR_THRESHOLD 600

`endif
